// ==== source/ip_hdr_pkg.sv ====
// IPv4 header package with field types, header struct and protocol numbers
`default_nettype none

package ip_hdr_pkg;

  // IPv4 address
  typedef logic [31:0] ip_addr_t;

  // Total length of the datagram in bytes
  typedef logic [15:0] ip_len_t;

  typedef logic [7:0] ip_proto_t;
  typedef logic [7:0] ip_ttl_t;

  // Traffic class split into DSCP and ECN
  typedef logic [5:0] ip_dscp_t;
  typedef logic [1:0] ip_ecn_t;

  // Header fields carried next to the payload stream
  typedef struct packed {
    ip_dscp_t  dscp;
    ip_ecn_t   ecn;
    ip_len_t   length;
    ip_ttl_t   ttl;
    ip_proto_t protocol;
    ip_addr_t  source_ip;
    ip_addr_t  dest_ip;
  } ip_hdr_t;

  // Protocol number that selects the UDP engine
  localparam ip_proto_t PROTO_UDP = 8'd17;

endpackage

`default_nettype wire

// ==== source/axis_pkg.sv ====
// Stream package with the 64-bit payload beat types and transmit source names
`default_nettype none

package axis_pkg;

  localparam int DATA_BYTES = 8;

  typedef logic [DATA_BYTES*8-1:0] axis_data_t;
  typedef logic [DATA_BYTES-1:0]   axis_keep_t;

  // One payload beat
  typedef struct packed {
    axis_data_t data;
    axis_keep_t keep;
    logic       last;
    logic       user;
  } axis_beat_t;

  typedef enum logic {SRC_UDP, SRC_IP} src_sel_t;

endpackage

`default_nettype wire

// ==== source/rx_protocol_demux.sv ====
// Receive demux that steers IP frames to the UDP or raw IP output by protocol
`timescale 1ns/1ps
`default_nettype none

module rx_protocol_demux (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in_hdr_valid,
  output logic                 in_hdr_ready,
  input  ip_hdr_pkg::ip_hdr_t  in_hdr,
  input  logic                 in_pay_valid,
  output logic                 in_pay_ready,
  input  axis_pkg::axis_beat_t in_pay,
  output logic                 udp_hdr_valid,
  input  logic                 udp_hdr_ready,
  output ip_hdr_pkg::ip_hdr_t  udp_hdr,
  output logic                 udp_pay_valid,
  input  logic                 udp_pay_ready,
  output axis_pkg::axis_beat_t udp_pay,
  output logic                 ip_hdr_valid,
  input  logic                 ip_hdr_ready,
  output ip_hdr_pkg::ip_hdr_t  ip_hdr,
  output logic                 ip_pay_valid,
  input  logic                 ip_pay_ready,
  output axis_pkg::axis_beat_t ip_pay
);

  logic is_udp;
  logic route_active;
  logic route_udp;
  logic hdr_fire;
  logic last_fire;

  assign is_udp = (in_hdr.protocol == ip_hdr_pkg::PROTO_UDP);

  // Header path closed while a payload is still in flight
  assign udp_hdr_valid = in_hdr_valid && !route_active && is_udp;
  assign ip_hdr_valid  = in_hdr_valid && !route_active && !is_udp;
  assign in_hdr_ready  = !route_active && (is_udp ? udp_hdr_ready : ip_hdr_ready);
  assign udp_hdr       = in_hdr;
  assign ip_hdr        = in_hdr;

  // Payload follows the latched route
  assign udp_pay_valid = in_pay_valid && route_active && route_udp;
  assign ip_pay_valid  = in_pay_valid && route_active && !route_udp;
  assign in_pay_ready  = route_active && (route_udp ? udp_pay_ready : ip_pay_ready);
  assign udp_pay       = in_pay;
  assign ip_pay        = in_pay;

  assign hdr_fire  = in_hdr_valid && in_hdr_ready;
  assign last_fire = in_pay_valid && in_pay_ready && in_pay.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      route_active <= 1'b0;
      route_udp    <= 1'b0;
    end else if (hdr_fire) begin
      route_active <= 1'b1;
      route_udp    <= is_udp;
    end else if (last_fire) begin
      route_active <= 1'b0;
    end
  end

  // Only one output carries payload at a time
  a_pay_onehot: assert property (
    @(posedge clk) disable iff (rst)
    !(udp_pay_valid && ip_pay_valid)
  );

  // Beats leave only inside a routed frame
  a_pay_in_frame: assert property (
    @(posedge clk) disable iff (rst)
    (udp_pay_valid || ip_pay_valid) |-> route_active
  );

endmodule

`default_nettype wire

// ==== source/tx_arb_ctrl.sv ====
// Fixed-priority frame grant FSM for the UDP and raw IP transmit sources
`timescale 1ns/1ps
`default_nettype none

module tx_arb_ctrl (
  input  logic               clk,
  input  logic               rst,
  input  logic               udp_hdr_valid,
  input  logic               ip_hdr_valid,
  input  logic               out_hdr_valid,
  input  logic               out_hdr_ready,
  input  logic               out_pay_valid,
  input  logic               out_pay_ready,
  input  logic               out_pay_last,
  output logic               grant_valid,
  output axis_pkg::src_sel_t grant_src,
  output logic               pay_phase
);

  typedef enum logic [1:0] {
    IDLE,
    HDR,
    PAY
  } state_t;

  state_t state;
  logic   hdr_fire;
  logic   last_fire;

  assign hdr_fire  = out_hdr_valid && out_hdr_ready;
  assign last_fire = out_pay_valid && out_pay_ready && out_pay_last;
  assign pay_phase = (state == PAY);

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= IDLE;
      grant_valid <= 1'b0;
      grant_src   <= axis_pkg::SRC_UDP;
    end else begin
      case (state)
        IDLE: begin
          // UDP engine wins a tie
          if (udp_hdr_valid) begin
            grant_valid <= 1'b1;
            grant_src   <= axis_pkg::SRC_UDP;
            state       <= HDR;
          end else if (ip_hdr_valid) begin
            grant_valid <= 1'b1;
            grant_src   <= axis_pkg::SRC_IP;
            state       <= HDR;
          end
        end
        HDR: begin
          if (hdr_fire) begin
            state <= PAY;
          end
        end
        PAY: begin
          if (last_fire) begin
            grant_valid <= 1'b0;
            state       <= IDLE;
          end
        end
        default: begin
          grant_valid <= 1'b0;
          state       <= IDLE;
        end
      endcase
    end
  end

  // Grant is locked for the whole frame
  a_grant_locked: assert property (
    @(posedge clk) disable iff (rst)
    (state != IDLE) |=> $stable(grant_src)
  );

endmodule

`default_nettype wire

// ==== source/tx_frame_mux.sv ====
// Transmit mux that passes the granted source's header and beats to the output
`timescale 1ns/1ps
`default_nettype none

module tx_frame_mux (
  input  logic                 grant_valid,
  input  axis_pkg::src_sel_t   grant_src,
  input  logic                 pay_phase,
  input  logic                 udp_hdr_valid,
  output logic                 udp_hdr_ready,
  input  ip_hdr_pkg::ip_hdr_t  udp_hdr,
  input  logic                 udp_pay_valid,
  output logic                 udp_pay_ready,
  input  axis_pkg::axis_beat_t udp_pay,
  input  logic                 ip_hdr_valid,
  output logic                 ip_hdr_ready,
  input  ip_hdr_pkg::ip_hdr_t  ip_hdr,
  input  logic                 ip_pay_valid,
  output logic                 ip_pay_ready,
  input  axis_pkg::axis_beat_t ip_pay,
  output logic                 out_hdr_valid,
  input  logic                 out_hdr_ready,
  output ip_hdr_pkg::ip_hdr_t  out_hdr,
  output logic                 out_pay_valid,
  input  logic                 out_pay_ready,
  output axis_pkg::axis_beat_t out_pay
);

  logic sel_udp;
  logic hdr_open;
  logic pay_open;

  assign sel_udp  = (grant_src == axis_pkg::SRC_UDP);
  assign hdr_open = grant_valid && !pay_phase;
  assign pay_open = grant_valid && pay_phase;

  assign out_hdr_valid = hdr_open && (sel_udp ? udp_hdr_valid : ip_hdr_valid);
  assign out_hdr       = sel_udp ? udp_hdr : ip_hdr;
  assign udp_hdr_ready = hdr_open && sel_udp && out_hdr_ready;
  assign ip_hdr_ready  = hdr_open && !sel_udp && out_hdr_ready;

  // Loser sees ready low until its own grant
  assign out_pay_valid = pay_open && (sel_udp ? udp_pay_valid : ip_pay_valid);
  assign out_pay       = sel_udp ? udp_pay : ip_pay;
  assign udp_pay_ready = pay_open && sel_udp && out_pay_ready;
  assign ip_pay_ready  = pay_open && !sel_udp && out_pay_ready;

  always_comb begin
    a_pay_granted: assert final (!out_pay_valid || (grant_valid && pay_phase));
  end

endmodule

`default_nettype wire

// ==== source/ip_proto_switch.sv ====
// IPv4 protocol switch top with receive demux and fixed-priority transmit arbiter
`timescale 1ns/1ps
`default_nettype none

module ip_proto_switch (
  input  logic                 clk,
  input  logic                 rst,
  // Frames from the IP stack
  input  logic                 rx_in_hdr_valid,
  output logic                 rx_in_hdr_ready,
  input  ip_hdr_pkg::ip_hdr_t  rx_in_hdr,
  input  logic                 rx_in_pay_valid,
  output logic                 rx_in_pay_ready,
  input  axis_pkg::axis_beat_t rx_in_pay,
  // UDP-bound receive output
  output logic                 udp_rx_hdr_valid,
  input  logic                 udp_rx_hdr_ready,
  output ip_hdr_pkg::ip_hdr_t  udp_rx_hdr,
  output logic                 udp_rx_pay_valid,
  input  logic                 udp_rx_pay_ready,
  output axis_pkg::axis_beat_t udp_rx_pay,
  // Raw IP receive output
  output logic                 ip_out_hdr_valid,
  input  logic                 ip_out_hdr_ready,
  output ip_hdr_pkg::ip_hdr_t  ip_out_hdr,
  output logic                 ip_out_pay_valid,
  input  logic                 ip_out_pay_ready,
  output axis_pkg::axis_beat_t ip_out_pay,
  // UDP engine transmit source
  input  logic                 udp_tx_hdr_valid,
  output logic                 udp_tx_hdr_ready,
  input  ip_hdr_pkg::ip_hdr_t  udp_tx_hdr,
  input  logic                 udp_tx_pay_valid,
  output logic                 udp_tx_pay_ready,
  input  axis_pkg::axis_beat_t udp_tx_pay,
  // Raw IP transmit source
  input  logic                 ip_tx_hdr_valid,
  output logic                 ip_tx_hdr_ready,
  input  ip_hdr_pkg::ip_hdr_t  ip_tx_hdr,
  input  logic                 ip_tx_pay_valid,
  output logic                 ip_tx_pay_ready,
  input  axis_pkg::axis_beat_t ip_tx_pay,
  // Merged frames toward the IP stack
  output logic                 tx_out_hdr_valid,
  input  logic                 tx_out_hdr_ready,
  output ip_hdr_pkg::ip_hdr_t  tx_out_hdr,
  output logic                 tx_out_pay_valid,
  input  logic                 tx_out_pay_ready,
  output axis_pkg::axis_beat_t tx_out_pay
);

  logic               grant_valid;
  axis_pkg::src_sel_t grant_src;
  logic               pay_phase;

  rx_protocol_demux i_rx_protocol_demux (
    .clk           (clk),
    .rst           (rst),
    .in_hdr_valid  (rx_in_hdr_valid),
    .in_hdr_ready  (rx_in_hdr_ready),
    .in_hdr        (rx_in_hdr),
    .in_pay_valid  (rx_in_pay_valid),
    .in_pay_ready  (rx_in_pay_ready),
    .in_pay        (rx_in_pay),
    .udp_hdr_valid (udp_rx_hdr_valid),
    .udp_hdr_ready (udp_rx_hdr_ready),
    .udp_hdr       (udp_rx_hdr),
    .udp_pay_valid (udp_rx_pay_valid),
    .udp_pay_ready (udp_rx_pay_ready),
    .udp_pay       (udp_rx_pay),
    .ip_hdr_valid  (ip_out_hdr_valid),
    .ip_hdr_ready  (ip_out_hdr_ready),
    .ip_hdr        (ip_out_hdr),
    .ip_pay_valid  (ip_out_pay_valid),
    .ip_pay_ready  (ip_out_pay_ready),
    .ip_pay        (ip_out_pay)
  );

  tx_arb_ctrl i_tx_arb_ctrl (
    .clk           (clk),
    .rst           (rst),
    .udp_hdr_valid (udp_tx_hdr_valid),
    .ip_hdr_valid  (ip_tx_hdr_valid),
    .out_hdr_valid (tx_out_hdr_valid),
    .out_hdr_ready (tx_out_hdr_ready),
    .out_pay_valid (tx_out_pay_valid),
    .out_pay_ready (tx_out_pay_ready),
    .out_pay_last  (tx_out_pay.last),
    .grant_valid   (grant_valid),
    .grant_src     (grant_src),
    .pay_phase     (pay_phase)
  );

  tx_frame_mux i_tx_frame_mux (
    .grant_valid   (grant_valid),
    .grant_src     (grant_src),
    .pay_phase     (pay_phase),
    .udp_hdr_valid (udp_tx_hdr_valid),
    .udp_hdr_ready (udp_tx_hdr_ready),
    .udp_hdr       (udp_tx_hdr),
    .udp_pay_valid (udp_tx_pay_valid),
    .udp_pay_ready (udp_tx_pay_ready),
    .udp_pay       (udp_tx_pay),
    .ip_hdr_valid  (ip_tx_hdr_valid),
    .ip_hdr_ready  (ip_tx_hdr_ready),
    .ip_hdr        (ip_tx_hdr),
    .ip_pay_valid  (ip_tx_pay_valid),
    .ip_pay_ready  (ip_tx_pay_ready),
    .ip_pay        (ip_tx_pay),
    .out_hdr_valid (tx_out_hdr_valid),
    .out_hdr_ready (tx_out_hdr_ready),
    .out_hdr       (tx_out_hdr),
    .out_pay_valid (tx_out_pay_valid),
    .out_pay_ready (tx_out_pay_ready),
    .out_pay       (tx_out_pay)
  );

endmodule

`default_nettype wire

// ==== dv/ip_proto_switch_tb.sv ====
// Testbench for the IPv4 protocol switch with queue-based checking assertions
`timescale 1ns/1ps
`default_nettype none

module ip_proto_switch_tb;

  localparam int TIMEOUT = 2000;

  logic  clk;
  logic  rst;
  logic  rand_ready;
  string test_name;

  // Source index 0 rx_in, 1 udp_tx, 2 ip_tx
  logic [2:0]           s_hv;
  logic [2:0]           s_hr;
  logic [2:0]           s_pv;
  logic [2:0]           s_pr;
  ip_hdr_pkg::ip_hdr_t  s_h [3];
  axis_pkg::axis_beat_t s_p [3];

  // Sink index 0 udp_rx, 1 ip_out, 2 tx_out
  logic [2:0]           o_hv;
  logic [2:0]           o_hr;
  logic [2:0]           o_pv;
  logic [2:0]           o_pr;
  ip_hdr_pkg::ip_hdr_t  o_h [3];
  axis_pkg::axis_beat_t o_p [3];

  ip_hdr_pkg::ip_hdr_t  hdr_q [3][$];
  axis_pkg::axis_beat_t pay_q [3][$];
  logic [2:0]           in_frame;

  ip_proto_switch i_ip_proto_switch (
    .clk (clk), .rst (rst),
    .rx_in_hdr_valid (s_hv[0]), .rx_in_hdr_ready (s_hr[0]), .rx_in_hdr (s_h[0]),
    .rx_in_pay_valid (s_pv[0]), .rx_in_pay_ready (s_pr[0]), .rx_in_pay (s_p[0]),
    .udp_rx_hdr_valid (o_hv[0]), .udp_rx_hdr_ready (o_hr[0]), .udp_rx_hdr (o_h[0]),
    .udp_rx_pay_valid (o_pv[0]), .udp_rx_pay_ready (o_pr[0]), .udp_rx_pay (o_p[0]),
    .ip_out_hdr_valid (o_hv[1]), .ip_out_hdr_ready (o_hr[1]), .ip_out_hdr (o_h[1]),
    .ip_out_pay_valid (o_pv[1]), .ip_out_pay_ready (o_pr[1]), .ip_out_pay (o_p[1]),
    .udp_tx_hdr_valid (s_hv[1]), .udp_tx_hdr_ready (s_hr[1]), .udp_tx_hdr (s_h[1]),
    .udp_tx_pay_valid (s_pv[1]), .udp_tx_pay_ready (s_pr[1]), .udp_tx_pay (s_p[1]),
    .ip_tx_hdr_valid (s_hv[2]), .ip_tx_hdr_ready (s_hr[2]), .ip_tx_hdr (s_h[2]),
    .ip_tx_pay_valid (s_pv[2]), .ip_tx_pay_ready (s_pr[2]), .ip_tx_pay (s_p[2]),
    .tx_out_hdr_valid (o_hv[2]), .tx_out_hdr_ready (o_hr[2]), .tx_out_hdr (o_h[2]),
    .tx_out_pay_valid (o_pv[2]), .tx_out_pay_ready (o_pr[2]), .tx_out_pay (o_p[2])
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "%s", msg);
  endtask

  // 0 UDP, 1 anything else, 2 either
  function automatic ip_hdr_pkg::ip_proto_t pick_proto(input int mode);
    if (mode == 0 || (mode == 2 && $urandom % 2 == 0)) begin
      return ip_hdr_pkg::PROTO_UDP;
    end
    return 8'(1 + $urandom % 16);
  endfunction

  task automatic build_frame(input int sink, input ip_hdr_pkg::ip_proto_t proto,
                             output ip_hdr_pkg::ip_hdr_t h,
                             output axis_pkg::axis_beat_t beats[$]);
    axis_pkg::axis_beat_t b;
    int n;
    h.dscp      = 6'($urandom);
    h.ecn       = 2'($urandom);
    h.length    = 16'($urandom);
    h.ttl       = 8'($urandom);
    h.protocol  = proto;
    h.source_ip = $urandom;
    h.dest_ip   = $urandom;
    hdr_q[sink].push_back(h);
    n = 1 + $urandom % 4;
    beats = {};
    for (int i = 0; i < n; i++) begin
      b.data = {$urandom, $urandom};
      b.last = (i == n - 1);
      b.keep = b.last ? 8'(1 + $urandom % 255) : 8'hff;
      b.user = 1'($urandom);
      beats.push_back(b);
      pay_q[sink].push_back(b);
    end
  endtask

  task automatic drive_hdr(input int s, input ip_hdr_pkg::ip_hdr_t h);
    int t;
    s_h[s]  = h;
    s_hv[s] = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (!s_hr[s] && t >= TIMEOUT) begin
        report_failure($sformatf("Timeout waiting for header handshake on source %0d", s));
      end
    end while (!s_hr[s]);
    #1;
    s_hv[s] = 1'b0;
  endtask

  task automatic drive_beat(input int s, input axis_pkg::axis_beat_t b);
    int t;
    s_p[s]  = b;
    s_pv[s] = 1'b1;
    t = 0;
    do begin
      @(posedge clk);
      t++;
      if (!s_pr[s] && t >= TIMEOUT) begin
        report_failure($sformatf("Timeout waiting for payload handshake on source %0d", s));
      end
    end while (!s_pr[s]);
    #1;
    s_pv[s] = 1'b0;
  endtask

  // Headers and beats run in parallel so a queued header meets an open frame
  task automatic run_rx_frames(input int nframes, input int mode);
    ip_hdr_pkg::ip_hdr_t  hdrs [$];
    axis_pkg::axis_beat_t beats [$];
    axis_pkg::axis_beat_t fb [$];
    ip_hdr_pkg::ip_hdr_t  h;
    ip_hdr_pkg::ip_proto_t proto;
    for (int f = 0; f < nframes; f++) begin
      proto = pick_proto(mode);
      build_frame((proto == ip_hdr_pkg::PROTO_UDP) ? 0 : 1, proto, h, fb);
      hdrs.push_back(h);
      foreach (fb[i]) beats.push_back(fb[i]);
    end
    fork
      foreach (hdrs[i]) drive_hdr(0, hdrs[i]);
      foreach (beats[i]) drive_beat(0, beats[i]);
    join
  endtask

  task automatic run_tx(input bit use_udp, input bit use_ip);
    ip_hdr_pkg::ip_hdr_t  uh;
    ip_hdr_pkg::ip_hdr_t  ih;
    axis_pkg::axis_beat_t ub [$];
    axis_pkg::axis_beat_t ib [$];
    // UDP frame is expected first whenever both are offered
    if (use_udp) build_frame(2, ip_hdr_pkg::PROTO_UDP, uh, ub);
    if (use_ip) build_frame(2, pick_proto(2), ih, ib);
    fork
      if (use_udp) drive_hdr(1, uh);
      foreach (ub[i]) drive_beat(1, ub[i]);
      if (use_ip) drive_hdr(2, ih);
      foreach (ib[i]) drive_beat(2, ib[i]);
    join
  endtask

  always begin
    @(posedge clk);
    #1;
    if (rand_ready) begin
      o_hr = 3'($urandom);
      o_pr = 3'($urandom);
    end else begin
      o_hr = 3'b111;
      o_pr = 3'b111;
    end
  end

  always @(posedge clk) begin
    logic [2:0] open;
    logic busy;
    open = in_frame;
    if (rst) begin
      in_frame = 3'b000;
    end else begin
      for (int p = 0; p < 3; p++) begin
        // Both receive outputs share one input stream
        busy = (p == 2) ? open[2] : (open[0] || open[1]);
        a_hdr_expected: assert (!o_hv[p] || hdr_q[p].size() > 0)
          else report_failure($sformatf("Header valid on output %0d with no frame expected in %s",
                                        p, test_name));
        a_pay_expected: assert (!o_pv[p] || pay_q[p].size() > 0)
          else report_failure($sformatf("Payload valid on output %0d with no beat expected in %s",
                                        p, test_name));
        if (o_hv[p] && o_hr[p]) begin
          a_hdr_framing: assert (!busy)
            else report_failure($sformatf("Header taken inside an open frame in %s", test_name));
          a_hdr_value: assert (o_h[p] == hdr_q[p][0])
            else report_failure($sformatf("Mismatch %s header: expected %h actual %h",
                                          test_name, hdr_q[p][0], o_h[p]));
          void'(hdr_q[p].pop_front());
          in_frame[p] = 1'b1;
        end
        if (o_pv[p] && o_pr[p]) begin
          a_pay_framing: assert (open[p])
            else report_failure($sformatf("Beat sent outside a frame in %s", test_name));
          a_pay_value: assert (o_p[p] == pay_q[p][0])
            else report_failure($sformatf("Mismatch %s beat: expected %h actual %h",
                                          test_name, pay_q[p][0], o_p[p]));
          void'(pay_q[p].pop_front());
          if (o_p[p].last) in_frame[p] = 1'b0;
        end
      end
    end
  end

  initial begin
    logic traffic_left;
    void'($urandom(32'h8ecc105e));
    rst        = 1'b1;
    rand_ready = 1'b0;
    s_hv       = 3'b000;
    s_pv       = 3'b000;
    o_hr       = 3'b111;
    o_pr       = 3'b111;
    foreach (s_h[i]) s_h[i] = '0;
    foreach (s_p[i]) s_p[i] = '0;
    test_name = "reset_state";
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (4) @(posedge clk);
    #1;

    test_name = "rx_routing";
    run_rx_frames(1, 0);
    run_rx_frames(1, 1);
    run_rx_frames(1, 0);

    test_name = "rx_backpressure";
    rand_ready = 1'b1;
    run_rx_frames(12, 2);

    test_name = "tx_single";
    rand_ready = 1'b0;
    run_tx(1'b1, 1'b0);
    run_tx(1'b0, 1'b1);

    test_name = "tx_priority";
    run_tx(1'b1, 1'b1);
    rand_ready = 1'b1;
    repeat (6) run_tx(1'b1, 1'b1);

    repeat (4) @(posedge clk);
    traffic_left = (in_frame != 3'b000);
    for (int p = 0; p < 3; p++) begin
      if (hdr_q[p].size() != 0 || pay_q[p].size() != 0) begin
        traffic_left = 1'b1;
      end
    end
    if (traffic_left) begin
      report_failure("Expected traffic was left over at the end of the run");
    end else begin
      $display("*** TEST PASSED ***");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== flist.f ====
source/ip_hdr_pkg.sv
source/axis_pkg.sv
source/rx_protocol_demux.sv
source/tx_arb_ctrl.sv
source/tx_frame_mux.sv
source/ip_proto_switch.sv
dv/ip_proto_switch_tb.sv

// ==== Bender.yml ====
package:
  name: ip_proto_switch

sources:
  - source/ip_hdr_pkg.sv
  - source/axis_pkg.sv
  - source/rx_protocol_demux.sv
  - source/tx_arb_ctrl.sv
  - source/tx_frame_mux.sv
  - source/ip_proto_switch.sv
  - target: test
    files:
      - dv/ip_proto_switch_tb.sv
